// ==== conv_pkg.sv ====
`default_nettype none

package conv_pkg;

	localparam int in_ch = 2;
	localparam int out_ch = 2;
	localparam int pix_w = 8;
	localparam int wt_w = 8;
	localparam int bias_w = 16;
	localparam int acc_w = 20;
	localparam int img_w = 6;
	localparam int img_h = 6;
	localparam int out_w = img_w - 2;
	localparam int out_h = img_h - 2;
	localparam int taps = 9;
	localparam int line_depth = img_w - 3;
	localparam int weight_words = taps * out_ch;
	localparam int bias_words = out_ch;

	// lane i of a word belongs to input channel i
	typedef logic signed [pix_w-1:0] pix_t;
	typedef pix_t [in_ch-1:0] pixel_word_t;
	typedef logic signed [wt_w-1:0] wt_t;
	typedef wt_t [in_ch-1:0] weight_word_t;

	// indexed [row][col] with row 0 and col 0 the oldest
	typedef pixel_word_t [2:0][2:0] window_t;
	typedef weight_word_t [taps-1:0][out_ch-1:0] weight_set_t;

	typedef logic signed [bias_w-1:0] bias_t;
	typedef bias_t [out_ch-1:0] bias_set_t;
	typedef logic signed [acc_w-1:0] acc_t;
	typedef acc_t [out_ch-1:0] result_t;

	typedef logic [7:0] addr_t;

	typedef enum logic [1:0] {load_idle, load_read, load_done} load_state_e;
	typedef enum logic [1:0] {scan_idle, scan_wait_coef, scan_run} scan_state_e;

endpackage

`default_nettype wire

// ==== window_builder.sv ====
`default_nettype none

module window_builder (
	input wire clk,
	input wire rst,
	input wire conv_pkg::pixel_word_t input_data,
	output conv_pkg::window_t window
);

	import conv_pkg::*;

	// line_buf[r] sits between the oldest tap of row r+1 and the newest tap of row r
	pixel_word_t line_buf [2][line_depth];

	// three row chains with the newest pixel entering at column 2
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			window <= '0;
		end
		else
		begin
			for (int r = 0; r < 3; r++)
			begin
				window[r][0] <= window[r][1];
				window[r][1] <= window[r][2];
			end
			window[2][2] <= input_data;
			window[1][2] <= line_buf[1][line_depth-1];
			window[0][2] <= line_buf[0][line_depth-1];
		end
	end

	// row delay is 2 taps + line_depth + 1, which is one image row
	always_ff @(posedge clk)
	begin
		for (int r = 0; r < 2; r++)
		begin
			line_buf[r][0] <= window[r+1][0];
			for (int d = 1; d < line_depth; d++)
			begin
				line_buf[r][d] <= line_buf[r][d-1];
			end
		end
	end

endmodule

`default_nettype wire

// ==== coef_loader.sv ====
`default_nettype none

module coef_loader (
	input wire clk,
	input wire rst,
	input wire weight_store_done,
	input wire bias_store_done,
	input wire conv_pkg::weight_word_t weight_data,
	input wire conv_pkg::bias_t bias_data,
	output logic read_weight_signal,
	output conv_pkg::addr_t read_weight_addr,
	output logic read_bias_signal,
	output conv_pkg::addr_t read_bias_addr,
	output conv_pkg::weight_set_t weights,
	output conv_pkg::bias_set_t biases,
	output logic coef_ready
);

	import conv_pkg::*;

	load_state_e w_state;
	load_state_e b_state;
	addr_t w_cnt;
	addr_t b_cnt;
	// capture flag and address trail the strobe by one cycle
	logic w_cap;
	logic b_cap;
	addr_t w_cap_addr;
	addr_t b_cap_addr;

	assign read_weight_signal = (w_state == load_read);
	assign read_weight_addr = w_cnt;
	assign read_bias_signal = (b_state == load_read);
	assign read_bias_addr = b_cnt;

	assign coef_ready = (w_state == load_done) && !w_cap && (b_state == load_done) && !b_cap;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			w_state <= load_idle;
			b_state <= load_idle;
			w_cnt <= '0;
			b_cnt <= '0;
			w_cap <= 1'b0;
			b_cap <= 1'b0;
			w_cap_addr <= '0;
			b_cap_addr <= '0;
		end
		else
		begin
			w_cap <= read_weight_signal;
			w_cap_addr <= w_cnt;
			b_cap <= read_bias_signal;
			b_cap_addr <= b_cnt;
			case (w_state)
				load_idle:
				begin
					if (weight_store_done)
					begin
						w_state <= load_read;
						w_cnt <= '0;
					end
				end
				load_read:
				begin
					if (w_cnt == addr_t'(weight_words - 1))
						w_state <= load_done;
					else
						w_cnt <= w_cnt + 1'b1;
				end
				load_done: w_state <= load_done;
				default: w_state <= load_idle;
			endcase
			case (b_state)
				load_idle:
				begin
					if (bias_store_done)
					begin
						b_state <= load_read;
						b_cnt <= '0;
					end
				end
				load_read:
				begin
					if (b_cnt == addr_t'(bias_words - 1))
						b_state <= load_done;
					else
						b_cnt <= b_cnt + 1'b1;
				end
				load_done: b_state <= load_done;
				default: b_state <= load_idle;
			endcase
		end
	end

	// word k -> tap k / out_ch, output channel k % out_ch
	always_ff @(posedge clk)
	begin
		if (w_cap)
			weights[w_cap_addr / out_ch][w_cap_addr % out_ch] <= weight_data;
		if (b_cap)
			biases[b_cap_addr] <= bias_data;
	end

	// strobes never run past the last word
	assert property (@(posedge clk) disable iff (rst)
		read_weight_signal |-> (read_weight_addr < addr_t'(weight_words)));
	assert property (@(posedge clk) disable iff (rst)
		read_bias_signal |-> (read_bias_addr < addr_t'(bias_words)));

endmodule

`default_nettype wire

// ==== conv_engine.sv ====
`default_nettype none

module conv_engine (
	input wire clk,
	input wire rst,
	input wire conv_pkg::window_t window,
	input wire conv_pkg::weight_set_t weights,
	input wire conv_pkg::bias_set_t biases,
	output conv_pkg::result_t output_data
);

	import conv_pkg::*;

	result_t sum_next;

	always_comb
	begin
		logic signed [pix_w-1:0] p;
		logic signed [wt_w-1:0] w;
		logic signed [bias_w-1:0] b;
		acc_t sum;
		for (int o = 0; o < out_ch; o++)
		begin
			b = biases[o];
			sum = b;
			// tap index is row * 3 + col
			for (int r = 0; r < 3; r++)
			begin
				for (int c = 0; c < 3; c++)
				begin
					for (int i = 0; i < in_ch; i++)
					begin
						p = window[r][c][i];
						w = weights[r*3+c][o][i];
						sum = sum + p * w;
					end
				end
			end
			sum_next[o] = sum;
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			output_data <= '0;
		else
			output_data <= sum_next;
	end

endmodule

`default_nettype wire

// ==== frame_scanner.sv ====
`default_nettype none

module frame_scanner (
	input wire clk,
	input wire rst,
	input wire pixel_store_done,
	input wire coef_ready,
	output logic read_pixel_signal,
	output conv_pkg::addr_t read_row_addr,
	output conv_pkg::addr_t read_col_addr,
	output logic save_enable,
	output conv_pkg::addr_t output_row,
	output conv_pkg::addr_t output_col,
	output logic layer2_calculation_done
);

	import conv_pkg::*;

	scan_state_e state;
	addr_t row_cnt;
	addr_t col_cnt;
	logic last_pos;
	// read position delayed to line up with the registered sum
	logic [2:0] pipe_valid;
	addr_t pipe_row [3];
	addr_t pipe_col [3];

	assign read_pixel_signal = (state == scan_run);
	assign read_row_addr = row_cnt;
	assign read_col_addr = col_cnt;
	assign last_pos = (row_cnt == addr_t'(img_h - 1)) && (col_cnt == addr_t'(img_w - 1));

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= scan_idle;
			row_cnt <= '0;
			col_cnt <= '0;
		end
		else
		begin
			case (state)
				scan_idle:
				begin
					if (pixel_store_done && coef_ready)
						state <= scan_run;
					else if (pixel_store_done)
						state <= scan_wait_coef;
				end
				scan_wait_coef:
				begin
					if (coef_ready)
						state <= scan_run;
				end
				scan_run:
				begin
					if (col_cnt == addr_t'(img_w - 1))
					begin
						col_cnt <= '0;
						row_cnt <= row_cnt + 1'b1;
					end
					else
					begin
						col_cnt <= col_cnt + 1'b1;
					end
					if (last_pos)
					begin
						state <= scan_idle;
						row_cnt <= '0;
					end
				end
				default: state <= scan_idle;
			endcase
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			pipe_valid <= '0;
			for (int k = 0; k < 3; k++)
			begin
				pipe_row[k] <= '0;
				pipe_col[k] <= '0;
			end
		end
		else
		begin
			pipe_valid <= {pipe_valid[1:0], read_pixel_signal};
			pipe_row[0] <= row_cnt;
			pipe_col[0] <= col_cnt;
			for (int k = 1; k < 3; k++)
			begin
				pipe_row[k] <= pipe_row[k-1];
				pipe_col[k] <= pipe_col[k-1];
			end
		end
	end

	// a full window exists once two rows and two columns are behind the read
	assign save_enable = pipe_valid[2] && (pipe_row[2] >= addr_t'(2)) && (pipe_col[2] >= addr_t'(2));
	assign output_row = pipe_row[2] - addr_t'(2);
	assign output_col = pipe_col[2] - addr_t'(2);
	assign layer2_calculation_done = save_enable && (pipe_row[2] == addr_t'(img_h - 1))
		&& (pipe_col[2] == addr_t'(img_w - 1));

	assert property (@(posedge clk) disable iff (rst)
		save_enable |-> (output_row < addr_t'(out_h)) && (output_col < addr_t'(out_w)));

endmodule

`default_nettype wire

// ==== layer2_conv.sv ====
`default_nettype none

module layer2_conv (
	input wire clk,
	input wire rst,
	input wire weight_store_done,
	input wire bias_store_done,
	input wire pixel_store_done,
	input wire conv_pkg::pixel_word_t input_data,
	input wire conv_pkg::weight_word_t weight_data,
	input wire conv_pkg::bias_t bias_data,
	output logic read_weight_signal,
	output conv_pkg::addr_t read_weight_addr,
	output logic read_bias_signal,
	output conv_pkg::addr_t read_bias_addr,
	output logic read_pixel_signal,
	output conv_pkg::addr_t read_row_addr,
	output conv_pkg::addr_t read_col_addr,
	output logic save_enable,
	output conv_pkg::addr_t output_row,
	output conv_pkg::addr_t output_col,
	output conv_pkg::result_t output_data,
	output logic layer2_calculation_done
);

	import conv_pkg::*;

	window_t window;
	weight_set_t weights;
	bias_set_t biases;
	logic coef_ready;

	window_builder window_builder_i (
		.clk(clk),
		.rst(rst),
		.input_data(input_data),
		.window(window)
	);

	coef_loader coef_loader_i (
		.clk(clk),
		.rst(rst),
		.weight_store_done(weight_store_done),
		.bias_store_done(bias_store_done),
		.weight_data(weight_data),
		.bias_data(bias_data),
		.read_weight_signal(read_weight_signal),
		.read_weight_addr(read_weight_addr),
		.read_bias_signal(read_bias_signal),
		.read_bias_addr(read_bias_addr),
		.weights(weights),
		.biases(biases),
		.coef_ready(coef_ready)
	);

	conv_engine conv_engine_i (
		.clk(clk),
		.rst(rst),
		.window(window),
		.weights(weights),
		.biases(biases),
		.output_data(output_data)
	);

	// reads start only once both coefficient sets are held
	frame_scanner frame_scanner_i (
		.clk(clk),
		.rst(rst),
		.pixel_store_done(pixel_store_done),
		.coef_ready(coef_ready),
		.read_pixel_signal(read_pixel_signal),
		.read_row_addr(read_row_addr),
		.read_col_addr(read_col_addr),
		.save_enable(save_enable),
		.output_row(output_row),
		.output_col(output_col),
		.layer2_calculation_done(layer2_calculation_done)
	);

endmodule

`default_nettype wire

// ==== conv_checker.sv ====
`default_nettype none

module conv_checker (
	input wire clk,
	input wire [2:0] phase,
	input wire phase_end,
	input wire read_weight_signal,
	input wire conv_pkg::addr_t read_weight_addr,
	input wire read_bias_signal,
	input wire conv_pkg::addr_t read_bias_addr,
	input wire read_pixel_signal,
	input wire conv_pkg::addr_t read_row_addr,
	input wire conv_pkg::addr_t read_col_addr,
	input wire save_enable,
	input wire conv_pkg::addr_t output_row,
	input wire conv_pkg::addr_t output_col,
	input wire conv_pkg::result_t output_data,
	input wire layer2_calculation_done,
	input logic [15:0] weight_mem [conv_pkg::weight_words],
	input logic [15:0] bias_mem [conv_pkg::bias_words],
	input logic [15:0] pixel_mem [conv_pkg::img_w * conv_pkg::img_h],
	output int total_errors
);

	timeunit 1ns;
	timeprecision 100ps;

	import conv_pkg::*;

	// error count per behavior numbered 1 to 6
	int errs [1:6];
	int w_cnt;
	int b_cnt;
	int pix_cnt;
	int save_cnt;
	int done_cnt;
	int data_cnt;

	always_comb
	begin
		total_errors = 0;
		for (int b = 1; b <= 6; b++)
			total_errors += errs[b];
	end

	// bias plus sum over taps and lanes for the window at (orow, ocol)
	function automatic int expected_sum(input int orow, input int ocol, input int o);
		int sum;
		logic [15:0] pix;
		logic [15:0] wt;
		sum = int'($signed(bias_mem[o]));
		for (int wr = 0; wr < 3; wr++)
		begin
			for (int wc = 0; wc < 3; wc++)
			begin
				pix = pixel_mem[(orow + wr) * img_w + ocol + wc];
				wt = weight_mem[(wr * 3 + wc) * out_ch + o];
				for (int i = 0; i < in_ch; i++)
					sum += int'($signed(pix[i*pix_w +: pix_w]))
						* int'($signed(wt[i*wt_w +: wt_w]));
			end
		end
		return sum;
	endfunction

	task automatic value_mismatch(input int b, input string sig, input int want, input int got);
		$display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, sig, want, got);
		errs[b]++;
	endtask

	task automatic flag_error(input int b, input string msg);
		$display("test %0d error at %0t: %s", b, $time, msg);
		errs[b]++;
	endtask

	task automatic report_test(input int b, input string name);
		if (errs[b] == 0)
			$display("test %0d %s: passed", b, name);
		else
			$display("test %0d %s: failed with %0d errors", b, name, errs[b]);
	endtask

	task automatic close_frame(input int data_bin);
		if (save_cnt != out_w * out_h)
			flag_error(4, $sformatf("frame gave %0d saves instead of 16", save_cnt));
		if (done_cnt != 1)
			flag_error(4, $sformatf("frame gave %0d done pulses instead of one", done_cnt));
		if (pix_cnt != img_w * img_h)
			flag_error(6, $sformatf("frame read %0d pixels instead of 36", pix_cnt));
		if (data_cnt == 0)
			flag_error(data_bin, "no output of the frame was compared");
	endtask

	task automatic close_phase();
		int passed;
		passed = 0;
		case (phase)
			3'd1: report_test(1, "quiet after reset");
			3'd2:
			begin
				if (w_cnt != weight_words)
					flag_error(2, $sformatf("%0d weight reads instead of 18", w_cnt));
				if (b_cnt != bias_words)
					flag_error(2, $sformatf("%0d bias reads instead of 2", b_cnt));
				report_test(2, "coefficient reads");
			end
			3'd3:
			begin
				close_frame(3);
				report_test(3, "first frame outputs");
			end
			3'd4:
			begin
				close_frame(5);
				report_test(4, "save order and done pulse");
				report_test(5, "second frame with stored coefficients");
				report_test(6, "pixel read coverage");
				for (int b = 1; b <= 6; b++)
				begin
					if (errs[b] == 0)
						passed++;
				end
				$display("tests: %0d passed, %0d failed, %0d errors in all",
					passed, 6 - passed, total_errors);
			end
			default: ;
		endcase
		pix_cnt = 0;
		save_cnt = 0;
		done_cnt = 0;
		data_cnt = 0;
	endtask

	always @(negedge clk)
	begin
		int want;
		int bin;
		bin = (phase == 3'd3) ? 3 : 5;
		if (phase == 3'd1 && (read_weight_signal || read_bias_signal || read_pixel_signal
			|| save_enable || layer2_calculation_done))
			flag_error(1, "a strobe or done was high before any store pulse");
		// a started load must strobe every cycle up to its last word
		if (!read_weight_signal && w_cnt > 0 && w_cnt < weight_words)
			flag_error(2, "weight read strobes stopped before the last address");
		if (!read_bias_signal && b_cnt > 0 && b_cnt < bias_words)
			flag_error(2, "bias read strobes stopped before the last address");
		if (read_weight_signal)
		begin
			if (w_cnt >= weight_words)
				flag_error(2, "weight read after the last address");
			else if (read_weight_addr != addr_t'(w_cnt))
				value_mismatch(2, "read_weight_addr", w_cnt, int'(read_weight_addr));
			w_cnt++;
		end
		if (read_bias_signal)
		begin
			if (b_cnt >= bias_words)
				flag_error(2, "bias read after the last address");
			else if (read_bias_addr != addr_t'(b_cnt))
				value_mismatch(2, "read_bias_addr", b_cnt, int'(read_bias_addr));
			b_cnt++;
		end
		if (read_pixel_signal)
		begin
			if (phase != 3'd3 && phase != 3'd4)
				flag_error(6, "pixel read outside a frame");
			else if (pix_cnt >= img_w * img_h)
				flag_error(6, "more pixel reads than the image holds");
			else
			begin
				if (read_row_addr != addr_t'(pix_cnt / img_w))
					value_mismatch(6, "read_row_addr", pix_cnt / img_w, int'(read_row_addr));
				if (read_col_addr != addr_t'(pix_cnt % img_w))
					value_mismatch(6, "read_col_addr", pix_cnt % img_w, int'(read_col_addr));
			end
			pix_cnt++;
		end
		if (layer2_calculation_done && !save_enable)
			flag_error(4, "done pulse without save_enable");
		if (save_enable)
		begin
			if (phase != 3'd3 && phase != 3'd4)
				flag_error(4, "save_enable was high outside a frame");
			else if (save_cnt >= out_w * out_h)
				flag_error(4, "more than one full output frame was saved");
			else
			begin
				if (int'(output_row) != save_cnt / out_w)
					value_mismatch(4, "output_row", save_cnt / out_w, int'(output_row));
				if (int'(output_col) != save_cnt % out_w)
					value_mismatch(4, "output_col", save_cnt % out_w, int'(output_col));
				if (layer2_calculation_done != (save_cnt == out_w * out_h - 1))
					value_mismatch(4, "layer2_calculation_done",
						int'(save_cnt == out_w * out_h - 1), int'(layer2_calculation_done));
				// compare at the reported position
				if (output_row < addr_t'(out_h) && output_col < addr_t'(out_w))
				begin
					for (int o = 0; o < out_ch; o++)
					begin
						want = expected_sum(int'(output_row), int'(output_col), o);
						if (int'(output_data[o]) != want)
							value_mismatch(bin, $sformatf("output_data[%0d]", o), want,
								int'(output_data[o]));
					end
					data_cnt++;
				end
			end
			save_cnt++;
		end
		if (layer2_calculation_done)
			done_cnt++;
		if (phase_end)
			close_phase();
	end

endmodule

`default_nettype wire

// ==== tb_layer2_conv.sv ====
`default_nettype none

module tb_layer2_conv;

	timeunit 1ns;
	timeprecision 100ps;

	import conv_pkg::*;

	localparam int reset_cycles = 8;
	localparam int coef_cycles = weight_words + 6;
	localparam int frame_cycles = img_w * img_h + 3 + 6;
	localparam int cycle_limit = 3 * (reset_cycles + 6 + coef_cycles + 2 * frame_cycles);

	logic clk;
	logic rst;
	logic weight_store_done;
	logic bias_store_done;
	logic pixel_store_done;
	pixel_word_t input_data = '0;
	weight_word_t weight_data = '0;
	bias_t bias_data = '0;
	logic read_weight_signal;
	addr_t read_weight_addr;
	logic read_bias_signal;
	addr_t read_bias_addr;
	logic read_pixel_signal;
	addr_t read_row_addr;
	addr_t read_col_addr;
	logic save_enable;
	addr_t output_row;
	addr_t output_col;
	result_t output_data;
	logic layer2_calculation_done;

	// external buffers
	logic [15:0] weight_mem [weight_words];
	logic [15:0] bias_mem [bias_words];
	logic [15:0] pixel_mem [img_w * img_h];
	logic w_req = 1'b0;
	logic b_req = 1'b0;
	logic p_req = 1'b0;
	addr_t w_req_addr = '0;
	addr_t b_req_addr = '0;
	int p_req_idx = 0;

	logic [15:0] lfsr = 16'd62192;
	logic [2:0] phase;
	logic phase_end;
	int cycles = 0;
	int total_errors;

	layer2_conv layer2_conv_i (.*);

	conv_checker conv_checker_i (.*);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic random_word(output logic [15:0] v);
		v = '0;
		for (int n = 0; n < 16; n++)
		begin
			lfsr = lfsr_step(lfsr);
			v = {v[14:0], lfsr[0]};
		end
	endtask

	task automatic fill_coefs();
		logic [15:0] v;
		for (int k = 0; k < weight_words; k++)
		begin
			random_word(v);
			weight_mem[k] = v;
		end
		for (int k = 0; k < bias_words; k++)
		begin
			random_word(v);
			bias_mem[k] = v;
		end
	endtask

	task automatic fill_pixels();
		logic [15:0] v;
		for (int k = 0; k < img_w * img_h; k++)
		begin
			random_word(v);
			pixel_mem[k] = v;
		end
	endtask

	task automatic end_phase(input logic [2:0] next_phase);
		@(negedge clk);
		phase_end <= 1'b1;
		@(negedge clk);
		phase_end <= 1'b0;
		phase <= next_phase;
	endtask

	task automatic run_frame();
		@(negedge clk);
		pixel_store_done <= 1'b1;
		@(negedge clk);
		pixel_store_done <= 1'b0;
		while (!layer2_calculation_done)
			@(negedge clk);
		repeat (3) @(negedge clk);
	endtask

	// synchronous buffers answer in the cycle after the strobe
	always @(negedge clk)
	begin
		weight_data <= w_req ? weight_mem[w_req_addr] : '0;
		bias_data <= b_req ? bias_mem[b_req_addr] : '0;
		input_data <= (p_req && p_req_idx < img_w * img_h) ? pixel_mem[p_req_idx] : '0;
		w_req <= read_weight_signal;
		w_req_addr <= read_weight_addr;
		b_req <= read_bias_signal;
		b_req_addr <= read_bias_addr;
		p_req <= read_pixel_signal;
		p_req_idx <= int'(read_row_addr) * img_w + int'(read_col_addr);
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit)
		begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("TB FAILED");
			$finish;
		end
	end

	initial
	begin
		rst = 1'b1;
		weight_store_done = 1'b0;
		bias_store_done = 1'b0;
		pixel_store_done = 1'b0;
		phase = 3'd1;
		phase_end = 1'b0;
		fill_coefs();
		fill_pixels();
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		rst <= 1'b0;
		repeat (6) @(negedge clk);
		end_phase(3'd2);
		@(negedge clk);
		weight_store_done <= 1'b1;
		bias_store_done <= 1'b1;
		@(negedge clk);
		weight_store_done <= 1'b0;
		bias_store_done <= 1'b0;
		while (!read_weight_signal)
			@(negedge clk);
		while (read_weight_signal)
			@(negedge clk);
		repeat (2) @(negedge clk);
		end_phase(3'd3);
		run_frame();
		end_phase(3'd4);
		// new pixels while the coefficients stay loaded
		fill_pixels();
		run_frame();
		end_phase(3'd5);
		@(negedge clk);
		if (total_errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== layer2_conv.f ====
conv_pkg.sv
window_builder.sv
coef_loader.sv
conv_engine.sv
frame_scanner.sv
layer2_conv.sv
conv_checker.sv
tb_layer2_conv.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f layer2_conv.f \
	--top-module tb_layer2_conv -o sim_tb_layer2_conv
out=$(./obj_dir/sim_tb_layer2_conv)
echo "$out"
if echo "$out" | grep -qx "TB PASSED"; then
	exit 0
fi
exit 1
